//--- src/noc_cfg_pkg.sv
// ============================================================
// Mesh configuration shared by all router blocks
// Coordinates are CoordW bits per axis, so the mesh is at
// most MeshDimX by MeshDimY tiles
// ============================================================

`default_nettype none

package noc_cfg_pkg;

  // A mesh router always has five ports
  localparam int unsigned NumPorts = 5;

  // Width of one mesh coordinate
  localparam int unsigned CoordW = 3;

  // Largest mesh that the coordinate width can address
  localparam int unsigned MeshDimX = 1 << CoordW;
  localparam int unsigned MeshDimY = 1 << CoordW;

  // Port order used by every per-port array
  typedef enum logic [2:0] {
    PortNorth = 3'd0,
    PortEast  = 3'd1,
    PortSouth = 3'd2,
    PortWest  = 3'd3,
    PortLocal = 3'd4
  } port_e;

  // Tile position in the mesh
  typedef struct packed {
    logic [CoordW-1:0] x;
    logic [CoordW-1:0] y;
  } coord_t;

endpackage

`default_nettype wire

//--- src/noc_flit_pkg.sv
// ============================================================
// Flit format of the three physical networks
// All networks share one header, only payload widths differ
// The header carries no flit type, last only marks a tail
// ============================================================

`default_nettype none

package noc_flit_pkg;

  // Payload of the narrow request network
  localparam int unsigned ReqPayloadW = 32;

  // Payload of the narrow response network
  localparam int unsigned RspPayloadW = 16;

  // Payload of the wide data network
  localparam int unsigned WidePayloadW = 64;

  // Routing header, 13 bits
  typedef struct packed {
    noc_cfg_pkg::coord_t dst;
    noc_cfg_pkg::coord_t src;
    logic                last;
  } flit_hdr_t;

endpackage

`default_nettype wire

//--- src/noc_link_if.sv
// ============================================================
// Valid/ready flit link inside one router
// A flit moves on each clock edge with valid and ready high
// The source holds valid and the flit stable until ready
// ============================================================

`timescale 1ns/10ps
`default_nettype none

interface noc_link_if #(
  parameter int unsigned PayloadW = 32
);

  import noc_flit_pkg::*;

  logic                valid;
  logic                ready;
  flit_hdr_t           hdr;
  logic [PayloadW-1:0] payload;

  // Side that offers flits
  modport src (
    output valid,
    output hdr,
    output payload,
    input  ready
  );

  // Side that takes flits
  modport dst (
    input  valid,
    input  hdr,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

//--- src/noc_in_port.sv
// ============================================================
// Router input port with a circular flit FIFO
// XY routing is done on the FIFO head against my_coord_i
// InFifoDepth must be at least 1, ready drops when full
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_in_port #(
  parameter int unsigned PayloadW    = 32,
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  noc_cfg_pkg::coord_t                 my_coord_i,
  noc_link_if.dst                             link_in,
  output logic [noc_cfg_pkg::NumPorts-1:0]    route_o,
  noc_link_if.src                             link_out
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int unsigned PtrW = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned CntW = $clog2(InFifoDepth + 1);

  flit_hdr_t           hdr_mem [InFifoDepth];
  logic [PayloadW-1:0] pl_mem  [InFifoDepth];
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  logic [CntW-1:0]     cnt_q;
  logic                push;
  logic                pop;
  flit_hdr_t           head_hdr;
  port_e               route_port;

  assign link_in.ready = (cnt_q != CntW'(InFifoDepth));
  assign push          = link_in.valid & link_in.ready;
  assign link_out.valid = (cnt_q != '0);
  assign pop           = link_out.valid & link_out.ready;

  assign head_hdr         = hdr_mem[rd_ptr_q];
  assign link_out.hdr     = head_hdr;
  assign link_out.payload = pl_mem[rd_ptr_q];

  // Header and payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      hdr_mem[wr_ptr_q] <= link_in.hdr;
      pl_mem[wr_ptr_q]  <= link_in.payload;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(InFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(InFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  // Dimension ordered, X first then Y
  always_comb begin
    if (head_hdr.dst.x > my_coord_i.x) begin
      route_port = PortEast;
    end else if (head_hdr.dst.x < my_coord_i.x) begin
      route_port = PortWest;
    end else if (head_hdr.dst.y > my_coord_i.y) begin
      route_port = PortNorth;
    end else if (head_hdr.dst.y < my_coord_i.y) begin
      route_port = PortSouth;
    end else begin
      route_port = PortLocal;
    end
  end

  assign route_o = link_out.valid ? (NumPorts'(1) << route_port) : '0;

endmodule

`default_nettype wire

//--- src/noc_out_port.sv
// ============================================================
// Router output port, round robin over all input ports
// One grant per cycle, only while the output register is free
// or being drained in the same cycle
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_out_port #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0] req_i,
  noc_link_if.dst                          in_links [noc_cfg_pkg::NumPorts],
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output noc_flit_pkg::flit_hdr_t          out_hdr_o,
  output logic [PayloadW-1:0]              out_payload_o
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int unsigned IdxW = $clog2(NumPorts);

  logic [NumPorts-1:0] in_valid;
  flit_hdr_t           in_hdr     [NumPorts];
  logic [PayloadW-1:0] in_payload [NumPorts];
  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] grant;
  logic [IdxW-1:0]     rr_q;
  logic [IdxW-1:0]     win_idx;
  logic                win_vld;
  logic                load_en;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_links
    assign in_valid[i]       = in_links[i].valid;
    assign in_hdr[i]         = in_links[i].hdr;
    assign in_payload[i]     = in_links[i].payload;
    assign in_links[i].ready = grant[i];
  end

  assign req     = req_i & in_valid;
  assign load_en = ~out_valid_o | out_ready_i;

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned idx;
    win_idx = rr_q;
    win_vld = 1'b0;
    for (int unsigned off = 0; off < NumPorts; off++) begin
      idx = rr_q + off;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!win_vld && req[idx]) begin
        win_vld = 1'b1;
        win_idx = IdxW'(idx);
      end
    end
  end

  assign grant = (win_vld && load_en) ? (NumPorts'(1) << win_idx) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q        <= '0;
      out_valid_o <= 1'b0;
    end else begin
      if (load_en) begin
        out_valid_o <= win_vld;
      end
      // Winner drops to lowest priority
      if (win_vld && load_en) begin
        rr_q <= (win_idx == IdxW'(NumPorts - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (win_vld && load_en) begin
      out_hdr_o     <= in_hdr[win_idx];
      out_payload_o <= in_payload[win_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/noc_router.sv
// ============================================================
// Generic five port XY router for one physical network
// Input FIFOs feed a full crossbar of round robin outputs
// No loopback check, a flit for Local may enter on Local
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_router #(
  parameter int unsigned PayloadW    = 32,
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  noc_cfg_pkg::coord_t                                my_coord_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                   valid_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                   ready_o,
  input  noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] hdr_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0][PayloadW-1:0]     payload_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                   valid_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                   ready_i,
  output noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] hdr_o,
  output logic [noc_cfg_pkg::NumPorts-1:0][PayloadW-1:0]     payload_o
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  // Route vectors indexed [input][output], grants [output][input]
  logic [NumPorts-1:0] route     [NumPorts];
  logic [NumPorts-1:0] req_col   [NumPorts];
  logic [NumPorts-1:0] grant_mat [NumPorts];
  logic [NumPorts-1:0] in_gnt;
  logic [NumPorts-1:0] fifo_valid;
  flit_hdr_t           fifo_hdr     [NumPorts];
  logic [PayloadW-1:0] fifo_payload [NumPorts];

  noc_link_if #(.PayloadW(PayloadW)) in_link   [NumPorts] ();
  noc_link_if #(.PayloadW(PayloadW)) fifo_link [NumPorts] ();

  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      in_gnt[i] = 1'b0;
      for (int unsigned o = 0; o < NumPorts; o++) begin
        req_col[o][i] = route[i][o];
        in_gnt[i]     = in_gnt[i] | grant_mat[o][i];
      end
    end
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    assign in_link[i].valid   = valid_i[i];
    assign in_link[i].hdr     = hdr_i[i];
    assign in_link[i].payload = payload_i[i];
    assign ready_o[i]         = in_link[i].ready;

    assign fifo_valid[i]      = fifo_link[i].valid;
    assign fifo_hdr[i]        = fifo_link[i].hdr;
    assign fifo_payload[i]    = fifo_link[i].payload;
    assign fifo_link[i].ready = in_gnt[i];

    noc_in_port #(
      .PayloadW    ( PayloadW    ),
      .InFifoDepth ( InFifoDepth )
    ) u_in_port (
      .clk_i      ( clk_i        ),
      .rst_n_i    ( rst_n_i      ),
      .my_coord_i ( my_coord_i   ),
      .link_in    ( in_link[i]   ),
      .route_o    ( route[i]     ),
      .link_out   ( fifo_link[i] )
    );
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    // Crossbar column, a private copy of every input link
    noc_link_if #(.PayloadW(PayloadW)) xbar_link [NumPorts] ();

    for (genvar i = 0; i < NumPorts; i++) begin : gen_xbar
      assign xbar_link[i].valid   = fifo_valid[i];
      assign xbar_link[i].hdr     = fifo_hdr[i];
      assign xbar_link[i].payload = fifo_payload[i];
      assign grant_mat[o][i]      = xbar_link[i].ready;
    end

    noc_out_port #(
      .PayloadW ( PayloadW )
    ) u_out_port (
      .clk_i         ( clk_i        ),
      .rst_n_i       ( rst_n_i      ),
      .req_i         ( req_col[o]   ),
      .in_links      ( xbar_link    ),
      .out_valid_o   ( valid_o[o]   ),
      .out_ready_i   ( ready_i[o]   ),
      .out_hdr_o     ( hdr_o[o]     ),
      .out_payload_o ( payload_o[o] )
    );
  end

endmodule

`default_nettype wire

//--- src/noc_nw_router.sv
// ============================================================
// Tile router with narrow request, narrow response and wide
// data networks, each an independent XY router
// All three share InFifoDepth, which must be at least 1
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_nw_router #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  noc_cfg_pkg::coord_t                                 my_coord_i,
  // Narrow request network
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    req_valid_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    req_ready_o,
  input  noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] req_hdr_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::ReqPayloadW-1:0] req_payload_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    req_valid_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    req_ready_i,
  output noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] req_hdr_o,
  output logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::ReqPayloadW-1:0] req_payload_o,
  // Narrow response network
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    rsp_valid_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    rsp_ready_o,
  input  noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] rsp_hdr_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::RspPayloadW-1:0] rsp_payload_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    rsp_valid_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    rsp_ready_i,
  output noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] rsp_hdr_o,
  output logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::RspPayloadW-1:0] rsp_payload_o,
  // Wide data network
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    wide_valid_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    wide_ready_o,
  input  noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] wide_hdr_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::WidePayloadW-1:0] wide_payload_i,
  output logic [noc_cfg_pkg::NumPorts-1:0]                    wide_valid_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    wide_ready_i,
  output noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] wide_hdr_o,
  output logic [noc_cfg_pkg::NumPorts-1:0][noc_flit_pkg::WidePayloadW-1:0] wide_payload_o
);

  import noc_flit_pkg::*;

  noc_router #(
    .PayloadW    ( ReqPayloadW ),
    .InFifoDepth ( InFifoDepth )
  ) u_req_router (
    .clk_i      ( clk_i         ),
    .rst_n_i    ( rst_n_i       ),
    .my_coord_i ( my_coord_i    ),
    .valid_i    ( req_valid_i   ),
    .ready_o    ( req_ready_o   ),
    .hdr_i      ( req_hdr_i     ),
    .payload_i  ( req_payload_i ),
    .valid_o    ( req_valid_o   ),
    .ready_i    ( req_ready_i   ),
    .hdr_o      ( req_hdr_o     ),
    .payload_o  ( req_payload_o )
  );

  noc_router #(
    .PayloadW    ( RspPayloadW ),
    .InFifoDepth ( InFifoDepth )
  ) u_rsp_router (
    .clk_i      ( clk_i         ),
    .rst_n_i    ( rst_n_i       ),
    .my_coord_i ( my_coord_i    ),
    .valid_i    ( rsp_valid_i   ),
    .ready_o    ( rsp_ready_o   ),
    .hdr_i      ( rsp_hdr_i     ),
    .payload_i  ( rsp_payload_i ),
    .valid_o    ( rsp_valid_o   ),
    .ready_i    ( rsp_ready_i   ),
    .hdr_o      ( rsp_hdr_o     ),
    .payload_o  ( rsp_payload_o )
  );

  // Wide data has its own buffers, so it never blocks the narrow nets
  noc_router #(
    .PayloadW    ( WidePayloadW ),
    .InFifoDepth ( InFifoDepth  )
  ) u_wide_router (
    .clk_i      ( clk_i          ),
    .rst_n_i    ( rst_n_i        ),
    .my_coord_i ( my_coord_i     ),
    .valid_i    ( wide_valid_i   ),
    .ready_o    ( wide_ready_o   ),
    .hdr_i      ( wide_hdr_i     ),
    .payload_i  ( wide_payload_i ),
    .valid_o    ( wide_valid_o   ),
    .ready_i    ( wide_ready_i   ),
    .hdr_o      ( wide_hdr_o     ),
    .payload_o  ( wide_payload_o )
  );

endmodule

`default_nettype wire

//--- tb/noc_router_checker.sv
// ============================================================
// Handshake assertions for one router, bound into noc_router
// fail_cnt counts failed assertions for the testbench summary
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_router_checker #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    valid_i,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    ready_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    valid_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0]                    ready_i,
  input  noc_flit_pkg::flit_hdr_t [noc_cfg_pkg::NumPorts-1:0] hdr_o,
  input  logic [noc_cfg_pkg::NumPorts-1:0][PayloadW-1:0]      payload_o
);

  import noc_cfg_pkg::*;

  int unsigned fail_cnt = 0;
  logic [31:0] in_total;
  logic [31:0] out_total;

  // Running totals of accepted and delivered flits
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_total  <= '0;
      out_total <= '0;
    end else begin
      in_total  <= in_total + $countones(valid_i & ready_o);
      out_total <= out_total + $countones(valid_o & ready_i);
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_hold
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_o[o] && !ready_i[o] |=>
        valid_o[o] && $stable(hdr_o[o]) && $stable(payload_o[o]))
    else begin
      fail_cnt++;
      $error("Output %0d changed or dropped its flit while stalled", o);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_total + $countones(valid_o & ready_i)) <= in_total)
  else begin
    fail_cnt++;
    $error("Output handshake without a matching input flit");
  end

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> (valid_o == '0))
  else begin
    fail_cnt++;
    $error("Valid output high right after reset");
  end

endmodule

bind noc_router noc_router_checker #(
  .PayloadW ( PayloadW )
) u_checker (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .valid_i   ( valid_i   ),
  .ready_o   ( ready_o   ),
  .valid_o   ( valid_o   ),
  .ready_i   ( ready_i   ),
  .hdr_o     ( hdr_o     ),
  .payload_o ( payload_o )
);

`default_nettype wire

//--- tb/noc_scoreboard.sv
// ============================================================
// Reference model of XY routing at tile (3,3)
// Source port is recovered from the source coordinate, so the
// stimulus must use one fixed neighbor per input port
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module noc_scoreboard (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic                                                      fair_en_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0]                     in_valid_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0]                     in_ready_i,
  input  noc_flit_pkg::flit_hdr_t [2:0][noc_cfg_pkg::NumPorts-1:0]  in_hdr_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0][63:0]               in_pl_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0]                     out_valid_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0]                     out_ready_i,
  input  noc_flit_pkg::flit_hdr_t [2:0][noc_cfg_pkg::NumPorts-1:0]  out_hdr_i,
  input  logic [2:0][noc_cfg_pkg::NumPorts-1:0][63:0]               out_pl_i,
  output int unsigned                                               err_cnt_o,
  output logic [2:0][31:0]                                          sent_o,
  output logic [2:0][31:0]                                          rcv_o
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  // One queue per network, input and output, entry is {hdr, payload}
  logic [76:0]      exp_q [75][$];
  int unsigned      skip  [3][5][5];
  int unsigned      err_cnt = 0;
  logic [2:0][31:0] sent = '0;
  logic [2:0][31:0] rcv = '0;

  assign err_cnt_o = err_cnt;
  assign sent_o    = sent;
  assign rcv_o     = rcv;

  function automatic int xy_port(input coord_t d);
    if (d.x > 3'd3) return int'(PortEast);
    if (d.x < 3'd3) return int'(PortWest);
    if (d.y > 3'd3) return int'(PortNorth);
    if (d.y < 3'd3) return int'(PortSouth);
    return int'(PortLocal);
  endfunction

  function automatic int src_port(input coord_t s);
    if (s.x == 3'd3 && s.y == 3'd4) return int'(PortNorth);
    if (s.x == 3'd4 && s.y == 3'd3) return int'(PortEast);
    if (s.x == 3'd3 && s.y == 3'd2) return int'(PortSouth);
    if (s.x == 3'd2 && s.y == 3'd3) return int'(PortWest);
    if (s.x == 3'd3 && s.y == 3'd3) return int'(PortLocal);
    return -1;
  endfunction

  task automatic report_missing();
    for (int k = 0; k < 75; k++) begin
      if (exp_q[k].size() != 0) begin
        $display("Flit never arrived: network %0d, input %0d, output %0d, hdr %h",
                 k / 25, (k / 5) % 5, k % 5, exp_q[k][0][76:64]);
      end
    end
  endtask

  always @(posedge clk_i) begin
    int          s;
    int          idx;
    logic [76:0] e;
    if (rst_n_i) begin
      // Outputs first, so a flit accepted on this edge is not yet pending
      for (int n = 0; n < 3; n++) begin
        for (int o = 0; o < 5; o++) begin
          if (out_valid_i[n][o] && out_ready_i[n][o]) begin
            rcv[n] = rcv[n] + 1;
            s = src_port(out_hdr_i[n][o].src);
            idx = n * 25 + s * 5 + o;
            if (s < 0) begin
              err_cnt++;
              $display("FAILED at %0t: net %0d out %0d bad source %h",
                       $time, n, o, out_hdr_i[n][o].src);
            end else if (exp_q[idx].size() == 0) begin
              err_cnt++;
              $display("FAILED at %0t: net %0d out %0d unexpected flit from input %0d",
                       $time, n, o, s);
            end else begin
              e = exp_q[idx].pop_front();
              if (e != {out_hdr_i[n][o], out_pl_i[n][o]}) begin
                err_cnt++;
                $display("FAILED at %0t: net %0d out %0d got %h expected %h",
                         $time, n, o, {out_hdr_i[n][o], out_pl_i[n][o]}, e);
              end
              // Round robin lets at most four other flits pass a waiting input
              for (int i = 0; i < 5; i++) begin
                if (!fair_en_i || i == s) begin
                  skip[n][i][o] = 0;
                end else if (exp_q[n * 25 + i * 5 + o].size() != 0) begin
                  skip[n][i][o]++;
                  if (skip[n][i][o] > 4) begin
                    err_cnt++;
                    $display("FAILED at %0t: net %0d out %0d passed over input %0d %0d times",
                             $time, n, o, i, skip[n][i][o]);
                  end
                end
              end
            end
          end
        end
      end
      for (int n = 0; n < 3; n++) begin
        for (int i = 0; i < 5; i++) begin
          if (in_valid_i[n][i] && in_ready_i[n][i]) begin
            sent[n] = sent[n] + 1;
            exp_q[n * 25 + i * 5 + xy_port(in_hdr_i[n][i].dst)].push_back(
              {in_hdr_i[n][i], in_pl_i[n][i]});
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_noc_nw_router.sv
// ============================================================
// Testbench for the tile router at coordinate (3,3)
// Random traffic from an LFSR, source coordinate is always the
// neighbor behind the input port
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module tb_noc_nw_router;

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  logic                           clk_i;
  logic                           rst_n_i;
  coord_t                         my_coord;
  logic [2:0][4:0]                in_valid;
  flit_hdr_t [2:0][4:0]           in_hdr;
  logic [2:0][4:0][63:0]          in_pl;
  logic [2:0][4:0]                out_ready;
  logic [2:0][4:0]                in_ready;
  logic [2:0][4:0]                out_valid;
  flit_hdr_t [2:0][4:0]           out_hdr;
  logic [2:0][4:0][63:0]          out_pl;
  logic [2:0][4:0][63:0]          dut_in_pl;
  logic [4:0][ReqPayloadW-1:0]    req_pl_i;
  logic [4:0][ReqPayloadW-1:0]    req_pl_o;
  logic [4:0][RspPayloadW-1:0]    rsp_pl_i;
  logic [4:0][RspPayloadW-1:0]    rsp_pl_o;
  logic [4:0][WidePayloadW-1:0]   wide_pl_i;
  logic [4:0][WidePayloadW-1:0]   wide_pl_o;
  int unsigned                    sb_err;
  logic [2:0][31:0]               sent;
  logic [2:0][31:0]               rcv;
  logic [31:0]                    lfsr_state = 32'hc400;
  int                             remain [3][5];
  bit                             hold_en [3];
  bit                             contend;
  bit                             fair_en;
  int unsigned                    tb_err;
  int unsigned                    err_mark;

  for (genvar p = 0; p < 5; p++) begin : gen_pl
    assign req_pl_i[p]     = in_pl[0][p][ReqPayloadW-1:0];
    assign rsp_pl_i[p]     = in_pl[1][p][RspPayloadW-1:0];
    assign wide_pl_i[p]    = in_pl[2][p];
    assign dut_in_pl[0][p] = {32'd0, req_pl_i[p]};
    assign dut_in_pl[1][p] = {48'd0, rsp_pl_i[p]};
    assign dut_in_pl[2][p] = wide_pl_i[p];
    assign out_pl[0][p]    = {32'd0, req_pl_o[p]};
    assign out_pl[1][p]    = {48'd0, rsp_pl_o[p]};
    assign out_pl[2][p]    = wide_pl_o[p];
  end

  noc_nw_router #(
    .InFifoDepth ( 2 )
  ) u_dut (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .my_coord_i     ( my_coord     ),
    .req_valid_i    ( in_valid[0]  ),
    .req_ready_o    ( in_ready[0]  ),
    .req_hdr_i      ( in_hdr[0]    ),
    .req_payload_i  ( req_pl_i     ),
    .req_valid_o    ( out_valid[0] ),
    .req_ready_i    ( out_ready[0] ),
    .req_hdr_o      ( out_hdr[0]   ),
    .req_payload_o  ( req_pl_o     ),
    .rsp_valid_i    ( in_valid[1]  ),
    .rsp_ready_o    ( in_ready[1]  ),
    .rsp_hdr_i      ( in_hdr[1]    ),
    .rsp_payload_i  ( rsp_pl_i     ),
    .rsp_valid_o    ( out_valid[1] ),
    .rsp_ready_i    ( out_ready[1] ),
    .rsp_hdr_o      ( out_hdr[1]   ),
    .rsp_payload_o  ( rsp_pl_o     ),
    .wide_valid_i   ( in_valid[2]  ),
    .wide_ready_o   ( in_ready[2]  ),
    .wide_hdr_i     ( in_hdr[2]    ),
    .wide_payload_i ( wide_pl_i    ),
    .wide_valid_o   ( out_valid[2] ),
    .wide_ready_i   ( out_ready[2] ),
    .wide_hdr_o     ( out_hdr[2]   ),
    .wide_payload_o ( wide_pl_o    )
  );

  noc_scoreboard u_sb (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .fair_en_i   ( fair_en   ),
    .in_valid_i  ( in_valid  ),
    .in_ready_i  ( in_ready  ),
    .in_hdr_i    ( in_hdr    ),
    .in_pl_i     ( dut_in_pl ),
    .out_valid_i ( out_valid ),
    .out_ready_i ( out_ready ),
    .out_hdr_i   ( out_hdr   ),
    .out_pl_i    ( out_pl    ),
    .err_cnt_o   ( sb_err    ),
    .sent_o      ( sent      ),
    .rcv_o       ( rcv       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2, 1, one step per returned bit
  function automatic logic [63:0] rand_bits(input int unsigned nbits);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int unsigned k = 0; k < nbits; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  // Neighbor tile behind each input port, Local is the tile itself
  function automatic coord_t neighbor(input int p);
    case (p)
      0:       return '{x: 3'd3, y: 3'd4};
      1:       return '{x: 3'd4, y: 3'd3};
      2:       return '{x: 3'd3, y: 3'd2};
      3:       return '{x: 3'd2, y: 3'd3};
      default: return '{x: 3'd3, y: 3'd3};
    endcase
  endfunction

  function automatic int unsigned total_errors();
    return sb_err + tb_err + u_dut.u_req_router.u_checker.fail_cnt
           + u_dut.u_rsp_router.u_checker.fail_cnt
           + u_dut.u_wide_router.u_checker.fail_cnt;
  endfunction

  // Traffic drivers and output back-pressure
  always @(posedge clk_i) begin
    flit_hdr_t h;
    if (rst_n_i) begin
      for (int n = 0; n < 3; n++) begin
        for (int p = 0; p < 5; p++) begin
          if (!in_valid[n][p] || in_ready[n][p]) begin
            if (remain[n][p] > 0 && (contend || rand_bits(1) == 64'd1)) begin
              h.dst.x = 3'(rand_bits(3));
              h.dst.y = 3'(rand_bits(3));
              if (contend) begin
                h.dst = '{x: 3'd3, y: 3'd3};
              end else if (p == 4 && h.dst.x == 3'd3 && h.dst.y == 3'd3) begin
                h.dst.x = 3'd4;
              end
              h.src  = neighbor(p);
              h.last = rand_bits(1) == 64'd1;
              in_hdr[n][p]   <= h;
              in_pl[n][p]    <= rand_bits(64);
              in_valid[n][p] <= 1'b1;
              remain[n][p]--;
            end else begin
              in_valid[n][p] <= 1'b0;
            end
          end
        end
        out_ready[n] <= hold_en[n] ? 5'(rand_bits(5)) : 5'h1f;
      end
    end
  end

  task automatic start_traffic(input int n, input int ports, input int count);
    for (int p = 0; p < ports; p++) begin
      remain[n][p] = count;
    end
  endtask

  task automatic wait_net_done(input int n, input int unsigned limit);
    int unsigned cyc;
    bit          busy;
    cyc  = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = (in_valid[n] != '0) || (sent[n] != rcv[n]);
      for (int p = 0; p < 5; p++) begin
        if (remain[n][p] != 0) begin
          busy = 1'b1;
        end
      end
      if (busy) begin
        cyc++;
        if (cyc > limit) begin
          $display("Timeout: network %0d did not deliver all flits within %0d cycles",
                   n, limit);
          u_sb.report_missing();
          $display("ERRORS FOUND");
          $finish;
        end
      end
    end
  endtask

  task automatic report_test(input string name);
    int unsigned errs;
    errs = total_errors() - err_mark;
    if (errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errs);
    end
    err_mark = total_errors();
  endtask

  initial begin
    rst_n_i   = 1'b0;
    my_coord  = '{x: 3'd3, y: 3'd3};
    in_valid  = '0;
    in_hdr    = '0;
    in_pl     = '0;
    out_ready = '1;
    contend   = 1'b0;
    fair_en   = 1'b0;
    tb_err    = 0;
    err_mark  = 0;
    for (int n = 0; n < 3; n++) begin
      hold_en[n] = 1'b0;
      start_traffic(n, 5, 0);
    end
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // 1: idle state after reset
    @(negedge clk_i);
    for (int n = 0; n < 3; n++) begin
      if (out_valid[n] != '0 || in_ready[n] != '1) begin
        tb_err++;
        $display("FAILED at %0t: net %0d valid %b ready %b after reset",
                 $time, n, out_valid[n], in_ready[n]);
      end
    end
    report_test("1 reset state");

    // 2 and 3: random traffic on every port of every network
    for (int n = 0; n < 3; n++) begin
      start_traffic(n, 5, 40);
    end
    for (int n = 0; n < 3; n++) begin
      wait_net_done(n, 20000);
    end
    report_test("2/3 XY routing, order and counts");

    // 4: narrow networks must drain while wide outputs stall
    @(negedge clk_i);
    hold_en[2] = 1'b1;
    for (int n = 0; n < 3; n++) begin
      start_traffic(n, 5, 30);
    end
    wait_net_done(0, 20000);
    wait_net_done(1, 20000);
    hold_en[2] = 1'b0;
    wait_net_done(2, 20000);
    report_test("4 wide back-pressure");

    // 5: four neighbors all aim at Local
    @(negedge clk_i);
    contend = 1'b1;
    fair_en = 1'b1;
    start_traffic(0, 4, 40);
    wait_net_done(0, 20000);
    contend = 1'b0;
    fair_en = 1'b0;
    report_test("5 round robin fairness");

    repeat (4) @(negedge clk_i);
    $display("Summary: %0d flits sent, %0d received, %0d errors",
             sent[0] + sent[1] + sent[2], rcv[0] + rcv[1] + rcv[2], total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
src/noc_cfg_pkg.sv
src/noc_flit_pkg.sv
src/noc_link_if.sv
src/noc_in_port.sv
src/noc_out_port.sv
src/noc_router.sv
src/noc_nw_router.sv
tb/noc_router_checker.sv
tb/noc_scoreboard.sv
tb/tb_noc_nw_router.sv
